// ==== Bender.yml ====
package:
  name: conv_acc

dependencies: {}

sources:
  # Packages first, then engines and top level
  - files:
      - verilog/acc_cfg_pkg.sv
      - verilog/acc_mem_pkg.sv
      - verilog/bus_switcher.sv
      - verilog/conv_1x1.sv
      - verilog/conv_3x3.sv
      - verilog/max_pool.sv
      - verilog/conv_acc.sv

  - target: simulation
    files:
      - verif/conv_acc_chk.sv
      - verif/conv_acc_tb.sv

// ==== list.f ====
verilog/acc_cfg_pkg.sv
verilog/acc_mem_pkg.sv
verilog/bus_switcher.sv
verilog/conv_1x1.sv
verilog/conv_3x3.sv
verilog/max_pool.sv
verilog/conv_acc.sv
verif/conv_acc_chk.sv
verif/conv_acc_tb.sv

// ==== verif/conv_acc_chk.sv ====
module conv_acc_chk #(
  parameter int FMAP_W = 8,
  parameter int FMAP_H = 8
) (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic                  finish_i,
  input acc_mem_pkg::mem_req_t param_req_i,
  input acc_mem_pkg::mem_req_t wgt_req_i,
  input acc_mem_pkg::mem_req_t in_req_i,
  input acc_mem_pkg::mem_req_t out_req_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int   fail_cnt = 0;
  logic stray_we;

  assign stray_we = (param_req_i.we && !param_req_i.en) || (wgt_req_i.we && !wgt_req_i.en) ||
                    (in_req_i.we && !in_req_i.en) || (out_req_i.we && !out_req_i.en);

  finish_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    finish_i |=> !finish_i) else begin
    fail_cnt = fail_cnt + 1;
    $error("finish high for two cycles in a row");
  end

  we_with_en: assert property (@(posedge clk_i) disable iff (!rst_n_i) !stray_we) else begin
    fail_cnt = fail_cnt + 1;
    $error("SRAM request has we set without en");
  end

  param_read_only: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !param_req_i.we) else begin
    fail_cnt = fail_cnt + 1;
    $error("parameter SRAM was written");
  end

  // Output writes stay inside the feature map
  out_addr_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_req_i.en && out_req_i.we) |-> (int'(out_req_i.addr) < FMAP_W * FMAP_H)) else begin
    fail_cnt = fail_cnt + 1;
    $error("output write address out of range");
  end

endmodule

bind conv_acc conv_acc_chk #(
  .FMAP_W (FMAP_W),
  .FMAP_H (FMAP_H)
) i_conv_acc_chk (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .finish_i    (finish_o),
  .param_req_i (param_req_o),
  .wgt_req_i   (wgt_req_o),
  .in_req_i    (in_req_o),
  .out_req_i   (out_req_o)
);

// ==== verif/conv_acc_tb.sv ====
module conv_acc_tb #(
  parameter int FMAP_W = 8,
  parameter int FMAP_H = 8
);
  timeunit 1ns;
  timeprecision 100ps;
  import acc_cfg_pkg::*;
  import acc_mem_pkg::*;

  localparam int NPIX        = FMAP_W * FMAP_H;
  localparam int CYCLE_LIMIT = 40 * (12 * NPIX + 50);

  logic      clk = 1'b0;
  logic      rst_n;
  logic      start;
  acc_mode_t mode;
  logic      finish;
  mem_req_t  param_req;
  mem_req_t  wgt_req;
  mem_req_t  in_req;
  mem_req_t  out_req;
  mem_word_t param_rdata = '0;
  mem_word_t wgt_rdata = '0;
  mem_word_t in_rdata = '0;

  // SRAM contents
  mem_word_t param_mem [1];
  mem_word_t wgt_mem [16];
  mem_word_t in_mem [NPIX];
  mem_word_t out_mem [NPIX];

  logic      clr_stats = 1'b0;
  int        wr_cnt;
  int        req_cnt;
  int        fin_cnt;
  int        cycle_cnt;
  int        hits [NPIX];
  pixel_t    exp_pix [NPIX];
  int        exp_n;

  conv_acc #(
    .FMAP_W (FMAP_W),
    .FMAP_H (FMAP_H)
  ) i_dut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .start_i       (start),
    .mode_i        (mode),
    .finish_o      (finish),
    .param_req_o   (param_req),
    .wgt_req_o     (wgt_req),
    .in_req_o      (in_req),
    .out_req_o     (out_req),
    .param_rdata_i (param_rdata),
    .wgt_rdata_i   (wgt_rdata),
    .in_rdata_i    (in_rdata)
  );

  always #4 clk = ~clk;

  // Synchronous SRAMs with one cycle of read latency
  always @(posedge clk) begin
    if (param_req.en && !param_req.we) begin
      param_rdata <= (param_req.addr == 16'd0) ? param_mem[0] : 'x;
    end
    if (wgt_req.en && !wgt_req.we) begin
      wgt_rdata <= (wgt_req.addr < 16'd16) ? wgt_mem[wgt_req.addr[3:0]] : 'x;
    end
    if (in_req.en && !in_req.we) begin
      in_rdata <= (int'(in_req.addr) < NPIX) ? in_mem[in_req.addr] : 'x;
    end
    if (out_req.en && out_req.we && (int'(out_req.addr) < NPIX)) begin
      out_mem[out_req.addr] <= out_req.wdata;
    end
    if (clr_stats) begin
      wr_cnt  <= 0;
      req_cnt <= 0;
      fin_cnt <= 0;
      for (int i = 0; i < NPIX; i++) begin
        hits[i] <= 0;
      end
    end else begin
      if (out_req.en && out_req.we) begin
        wr_cnt <= wr_cnt + 1;
        if (int'(out_req.addr) < NPIX) begin
          hits[out_req.addr] <= hits[out_req.addr] + 1;
        end
      end
      if (param_req.en || wgt_req.en || in_req.en || out_req.en) begin
        req_cnt <= req_cnt + 1;
      end
      if (finish) begin
        fin_cnt <= fin_cnt + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      fail_run("Timeout, the tests did not complete within the cycle limit");
    end
  end

  always @(negedge clk) begin
    if (i_dut.i_conv_acc_chk.fail_cnt != 0) begin
      fail_run("A protocol assertion on the DUT ports failed");
    end
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "Stopping after the first error");
  endtask

  task automatic check_pixel(input string name, input pixel_t expected, input pixel_t actual);
    if (expected !== actual) begin
      fail_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (expected != actual) begin
      fail_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  task automatic check_word(input string name, input mem_word_t expected,
                            input mem_word_t actual);
    if (expected !== actual) begin
      fail_run($sformatf("Mismatch %s: expected 0x%08h, actual 0x%08h", name, expected,
                         actual));
    end
  endtask

  task automatic clear_stats();
    clr_stats = 1'b1;
    @(negedge clk);
    clr_stats = 1'b0;
  endtask

  function automatic pixel_t rand_pix();
    return pixel_t'($urandom_range(0, 255));
  endfunction

  function automatic pixel_t edge_pix();
    return ($urandom_range(0, 1) != 0) ? 8'sd127 : -8'sd128;
  endfunction

  function automatic int in_val(input int idx);
    return int'(pixel_t'(in_mem[idx][7:0]));
  endfunction

  function automatic int wgt_val(input int idx);
    return int'(pixel_t'(wgt_mem[idx][7:0]));
  endfunction

  // Arithmetic shift, ReLU, int8 saturation
  function automatic pixel_t scale_clamp(input int acc, input conv_param_t p);
    int v;
    v = acc >>> p.shift;
    if (p.relu_en && (v < 0)) begin
      v = 0;
    end
    if (v > 127) begin
      v = 127;
    end else if (v < -128) begin
      v = -128;
    end
    return pixel_t'(v);
  endfunction

  task automatic load_fmap(input bit extreme);
    pixel_t p;
    for (int i = 0; i < NPIX; i++) begin
      p = extreme ? edge_pix() : rand_pix();
      in_mem[i] = 32'(p);
    end
  endtask

  task automatic set_conv_param(input bit extreme);
    layer_param_u prm;
    pixel_t       w;
    prm              = '0;
    prm.conv.bias    = extreme ? 16'd0 : 16'($urandom_range(0, 1023)) - 16'd512;
    prm.conv.shift   = extreme ? 4'd0 : 4'($urandom_range(0, 7));
    prm.conv.relu_en = 1'($urandom_range(0, 1));
    param_mem[0]     = prm;
    for (int k = 0; k < 16; k++) begin
      w = extreme ? edge_pix() : rand_pix();
      wgt_mem[k] = (k < 9) ? 32'(w) : '0;
    end
  endtask

  task automatic set_pool_param();
    layer_param_u prm;
    prm            = '0;
    prm.pool.floor = pixel_t'(8'($urandom_range(0, 127)) - 8'd64);
    param_mem[0]   = prm;
  endtask

  task automatic pointwise_model();
    layer_param_u u;
    u = param_mem[0];
    for (int i = 0; i < NPIX; i++) begin
      exp_pix[i] = scale_clamp(in_val(i) * wgt_val(0) + int'(u.conv.bias), u.conv);
    end
    exp_n = NPIX;
  endtask

  task automatic window_model();
    layer_param_u u;
    int           acc;
    u = param_mem[0];
    for (int r = 0; r < FMAP_H - 2; r++) begin
      for (int c = 0; c < FMAP_W - 2; c++) begin
        acc = int'(u.conv.bias);
        for (int kr = 0; kr < 3; kr++) begin
          for (int kc = 0; kc < 3; kc++) begin
            acc += in_val((r + kr) * FMAP_W + c + kc) * wgt_val(kr * 3 + kc);
          end
        end
        exp_pix[r * (FMAP_W - 2) + c] = scale_clamp(acc, u.conv);
      end
    end
    exp_n = (FMAP_H - 2) * (FMAP_W - 2);
  endtask

  task automatic pool_model();
    layer_param_u u;
    int           m;
    u = param_mem[0];
    for (int r = 0; r < FMAP_H / 2; r++) begin
      for (int c = 0; c < FMAP_W / 2; c++) begin
        m = -128;
        for (int d = 0; d < 4; d++) begin
          if (in_val((2 * r + d / 2) * FMAP_W + 2 * c + d % 2) > m) begin
            m = in_val((2 * r + d / 2) * FMAP_W + 2 * c + d % 2);
          end
        end
        if (m < int'(u.pool.floor)) begin
          m = int'(u.pool.floor);
        end
        exp_pix[r * (FMAP_W / 2) + c] = pixel_t'(m);
      end
    end
    exp_n = NPIX / 4;
  endtask

  // One layer run with an optional second start while busy
  task automatic run_engine(input string name, input acc_mode_t m, input bit restart);
    clear_stats();
    mode  = m;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    if (restart) begin
      repeat (4) @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
    end
    while (!finish) begin
      @(negedge clk);
    end
    check_count({name, " writes"}, exp_n, wr_cnt);
    for (int i = 0; i < exp_n; i++) begin
      check_count($sformatf("%s hits at %0d", name, i), 1, hits[i]);
      check_pixel($sformatf("%s pixel %0d", name, i), exp_pix[i], pixel_t'(out_mem[i][7:0]));
      // Pixel is sign-extended over the whole word
      check_word($sformatf("%s word %0d", name, i), 32'(exp_pix[i]), out_mem[i]);
    end
  endtask

  task automatic exercise_conv1(input string name, input bit restart);
    load_fmap(1'b0);
    set_conv_param(1'b0);
    pointwise_model();
    run_engine(name, MODE_CONV_1X1, restart);
  endtask

  task automatic exercise_conv3(input string name, input bit restart, input bit extreme);
    load_fmap(extreme);
    set_conv_param(extreme);
    window_model();
    run_engine(name, MODE_CONV_3X3, restart);
  endtask

  task automatic exercise_pool(input string name, input bit restart);
    load_fmap(1'b0);
    set_pool_param();
    pool_model();
    run_engine(name, MODE_MAX_POOL, restart);
  endtask

  task automatic unused_mode_probe(input string name);
    mem_word_t snap [NPIX];
    snap = out_mem;
    clear_stats();
    mode  = acc_mode_t'(4'hA);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    repeat (200) @(negedge clk);
    check_count({name, " finish pulses"}, 0, fin_cnt);
    check_count({name, " requests"}, 0, req_cnt);
    check_count({name, " writes"}, 0, wr_cnt);
    for (int i = 0; i < NPIX; i++) begin
      check_word($sformatf("%s word %0d", name, i), snap[i], out_mem[i]);
    end
  endtask

  initial begin
    int sel;
    void'($urandom(31685));
    rst_n = 1'b0;
    start = 1'b0;
    mode  = MODE_CONV_1X1;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int k = 0; k < 6; k++) begin
      exercise_conv1($sformatf("conv1x1 run %0d", k), 1'b0);
    end
    for (int k = 0; k < 6; k++) begin
      exercise_conv3($sformatf("conv3x3 run %0d", k), 1'b0, k >= 4);
    end
    for (int k = 0; k < 6; k++) begin
      exercise_pool($sformatf("pool run %0d", k), 1'b0);
    end
    exercise_conv1("conv1x1 restart", 1'b1);
    exercise_conv3("conv3x3 restart", 1'b1, 1'b0);
    exercise_pool("pool restart", 1'b1);
    unused_mode_probe("unused mode");
    // Mixed modes back to back
    for (int k = 0; k < 12; k++) begin
      sel = $urandom_range(0, 2);
      case (sel)
        0: exercise_conv1($sformatf("mixed conv1x1 %0d", k), 1'b0);
        1: exercise_conv3($sformatf("mixed conv3x3 %0d", k), 1'b0, 1'b0);
        default: exercise_pool($sformatf("mixed pool %0d", k), 1'b0);
      endcase
    end
    if (i_dut.i_conv_acc_chk.fail_cnt == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      fail_run("Protocol assertions failed during the run");
    end
  end

endmodule

// ==== verilog/acc_cfg_pkg.sv ====
package acc_cfg_pkg;

  typedef enum logic [3:0] {
    MODE_CONV_1X1 = 4'h1,
    MODE_CONV_3X3 = 4'h2,
    MODE_MAX_POOL = 4'h3
  } acc_mode_t;

  typedef logic signed [7:0] pixel_t;

  typedef struct packed {
    logic signed [15:0] bias;
    logic [3:0]         shift;
    logic               relu_en;
    logic [10:0]        rsvd;
  } conv_param_t;

  typedef struct packed {
    pixel_t      floor;
    logic [23:0] rsvd;
  } pool_param_t;

  // Word at parameter address 0
  typedef union packed {
    conv_param_t conv;
    pool_param_t pool;
  } layer_param_u;

  // Shift, optional ReLU, then clamp to int8
  function automatic pixel_t conv_post(input logic signed [31:0] acc, input conv_param_t prm);
    logic signed [31:0] sh;
    sh = acc >>> prm.shift;
    if (prm.relu_en && (sh < 0)) begin
      sh = '0;
    end
    if (sh > 32'sd127) begin
      return 8'sd127;
    end
    if (sh < -32'sd128) begin
      return -8'sd128;
    end
    return pixel_t'(sh);
  endfunction

endpackage

// ==== verilog/acc_mem_pkg.sv ====
package acc_mem_pkg;

  typedef logic [31:0] mem_word_t;

  // Single-port SRAM request sampled on every clock
  typedef struct packed {
    logic        en;
    logic        we;
    logic [15:0] addr;
    mem_word_t   wdata;
  } mem_req_t;

endpackage

// ==== verilog/bus_switcher.sv ====
module bus_switcher (
  input  acc_cfg_pkg::acc_mode_t mode_i,
  input  logic                   start_i,
  output logic                   finish_o,
  output acc_mem_pkg::mem_req_t  param_req_o,
  output acc_mem_pkg::mem_req_t  wgt_req_o,
  output acc_mem_pkg::mem_req_t  in_req_o,
  output acc_mem_pkg::mem_req_t  out_req_o,
  // 1x1 convolution
  output logic                   c1_start_o,
  input  logic                   c1_finish_i,
  input  acc_mem_pkg::mem_req_t  c1_param_req_i,
  input  acc_mem_pkg::mem_req_t  c1_wgt_req_i,
  input  acc_mem_pkg::mem_req_t  c1_in_req_i,
  input  acc_mem_pkg::mem_req_t  c1_out_req_i,
  // 3x3 convolution
  output logic                   c3_start_o,
  input  logic                   c3_finish_i,
  input  acc_mem_pkg::mem_req_t  c3_param_req_i,
  input  acc_mem_pkg::mem_req_t  c3_wgt_req_i,
  input  acc_mem_pkg::mem_req_t  c3_in_req_i,
  input  acc_mem_pkg::mem_req_t  c3_out_req_i,
  // Max pool
  output logic                   mp_start_o,
  input  logic                   mp_finish_i,
  input  acc_mem_pkg::mem_req_t  mp_param_req_i,
  input  acc_mem_pkg::mem_req_t  mp_in_req_i,
  input  acc_mem_pkg::mem_req_t  mp_out_req_i
);
  import acc_cfg_pkg::*;

  always_comb begin
    c1_start_o  = 1'b0;
    c3_start_o  = 1'b0;
    mp_start_o  = 1'b0;
    finish_o    = 1'b0;
    param_req_o = '0;
    wgt_req_o   = '0;
    in_req_o    = '0;
    out_req_o   = '0;
    case (mode_i)
      MODE_CONV_1X1: begin
        c1_start_o  = start_i;
        finish_o    = c1_finish_i;
        param_req_o = c1_param_req_i;
        wgt_req_o   = c1_wgt_req_i;
        in_req_o    = c1_in_req_i;
        out_req_o   = c1_out_req_i;
      end
      MODE_CONV_3X3: begin
        c3_start_o  = start_i;
        finish_o    = c3_finish_i;
        param_req_o = c3_param_req_i;
        wgt_req_o   = c3_wgt_req_i;
        in_req_o    = c3_in_req_i;
        out_req_o   = c3_out_req_i;
      end
      MODE_MAX_POOL: begin
        // No weights needed here
        mp_start_o  = start_i;
        finish_o    = mp_finish_i;
        param_req_o = mp_param_req_i;
        in_req_o    = mp_in_req_i;
        out_req_o   = mp_out_req_i;
      end
      default: begin
        // Unused code leaves everything disconnected
      end
    endcase
  end

endmodule

// ==== verilog/conv_1x1.sv ====
module conv_1x1 #(
  parameter int FMAP_W = 8,
  parameter int FMAP_H = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   start_i,
  output logic                   finish_o,
  output acc_mem_pkg::mem_req_t  param_req_o,
  output acc_mem_pkg::mem_req_t  wgt_req_o,
  output acc_mem_pkg::mem_req_t  in_req_o,
  output acc_mem_pkg::mem_req_t  out_req_o,
  input  acc_mem_pkg::mem_word_t param_rdata_i,
  input  acc_mem_pkg::mem_word_t wgt_rdata_i,
  input  acc_mem_pkg::mem_word_t in_rdata_i
);
  import acc_cfg_pkg::*;
  import acc_mem_pkg::*;

  localparam int NPIX = FMAP_W * FMAP_H;

  typedef enum logic [1:0] {S_IDLE, S_CFG, S_RUN, S_DRAIN} state_t;

  state_t             state_q;
  mem_req_t           param_req_q;
  mem_req_t           wgt_req_q;
  mem_req_t           in_req_q;
  mem_req_t           out_req_q;
  logic               cfg_vld_q;
  logic               pix_vld_q;
  logic               mul_vld_q;
  logic               finish_q;
  logic [15:0]        wr_addr_q;
  layer_param_u       prm_q;
  pixel_t             wgt_q;
  logic signed [31:0] acc_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= S_IDLE;
      param_req_q <= '0;
      wgt_req_q   <= '0;
      in_req_q    <= '0;
      out_req_q   <= '0;
      cfg_vld_q   <= 1'b0;
      pix_vld_q   <= 1'b0;
      mul_vld_q   <= 1'b0;
      finish_q    <= 1'b0;
      wr_addr_q   <= '0;
    end else begin
      param_req_q.en <= 1'b0;
      wgt_req_q.en   <= 1'b0;
      finish_q       <= 1'b0;
      // Read data shows up one cycle after the request
      cfg_vld_q      <= param_req_q.en;
      pix_vld_q      <= in_req_q.en;
      mul_vld_q      <= pix_vld_q;
      out_req_q.en   <= mul_vld_q;
      out_req_q.we   <= mul_vld_q;
      if (mul_vld_q) begin
        out_req_q.addr  <= wr_addr_q;
        out_req_q.wdata <= 32'(conv_post(acc_q, prm_q.conv));
        wr_addr_q       <= wr_addr_q + 16'd1;
      end
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            param_req_q.en <= 1'b1;
            wgt_req_q.en   <= 1'b1;
            wr_addr_q      <= '0;
            state_q        <= S_CFG;
          end
        end
        S_CFG: begin
          if (cfg_vld_q) begin
            in_req_q.en   <= 1'b1;
            in_req_q.addr <= '0;
            state_q       <= S_RUN;
          end
        end
        S_RUN: begin
          if (in_req_q.addr == 16'(NPIX - 1)) begin
            in_req_q.en <= 1'b0;
            state_q     <= S_DRAIN;
          end else begin
            in_req_q.addr <= in_req_q.addr + 16'd1;
          end
        end
        S_DRAIN: begin
          if (out_req_q.en && (out_req_q.addr == 16'(NPIX - 1))) begin
            finish_q <= 1'b1;
            state_q  <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Multiply stage
  always_ff @(posedge clk_i) begin
    if (cfg_vld_q) begin
      prm_q <= param_rdata_i;
      wgt_q <= pixel_t'(wgt_rdata_i[7:0]);
    end
    if (pix_vld_q) begin
      acc_q <= pixel_t'(in_rdata_i[7:0]) * wgt_q + prm_q.conv.bias;
    end
  end

  assign param_req_o = param_req_q;
  assign wgt_req_o   = wgt_req_q;
  assign in_req_o    = in_req_q;
  assign out_req_o   = out_req_q;
  assign finish_o    = finish_q;

endmodule

// ==== verilog/conv_3x3.sv ====
module conv_3x3 #(
  parameter int FMAP_W = 8,
  parameter int FMAP_H = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   start_i,
  output logic                   finish_o,
  output acc_mem_pkg::mem_req_t  param_req_o,
  output acc_mem_pkg::mem_req_t  wgt_req_o,
  output acc_mem_pkg::mem_req_t  in_req_o,
  output acc_mem_pkg::mem_req_t  out_req_o,
  input  acc_mem_pkg::mem_word_t param_rdata_i,
  input  acc_mem_pkg::mem_word_t wgt_rdata_i,
  input  acc_mem_pkg::mem_word_t in_rdata_i
);
  import acc_cfg_pkg::*;
  import acc_mem_pkg::*;

  localparam int OUT_W = FMAP_W - 2;
  localparam int OUT_H = FMAP_H - 2;

  typedef enum logic [2:0] {S_IDLE, S_LOAD, S_ISSUE, S_WAIT, S_LAST} state_t;

  state_t             state_q;
  mem_req_t           param_req_q;
  mem_req_t           wgt_req_q;
  mem_req_t           in_req_q;
  mem_req_t           out_req_q;
  logic               param_vld_q;
  logic               wgt_vld_q;
  logic               rd_vld_q;
  logic               finish_q;
  logic [3:0]         wgt_idx_q;
  logic [3:0]         req_k_q;
  logic [3:0]         rd_k_q;
  logic [3:0]         inflight_q;
  logic [1:0]         kr_q;
  logic [1:0]         kc_q;
  logic [15:0]        orow_q;
  logic [15:0]        ocol_q;
  logic [15:0]        wr_addr_q;
  logic [15:0]        rd_addr;
  logic               load_done;
  logic               win_done;
  layer_param_u       prm_q;
  pixel_t             wgt_q [9];
  logic signed [31:0] acc_q;

  assign rd_addr   = 16'((orow_q + 16'(kr_q)) * FMAP_W + ocol_q + 16'(kc_q));
  assign load_done = (state_q == S_LOAD) && wgt_vld_q && (wgt_idx_q == 4'd8);
  // All nine products are in the accumulator
  assign win_done  = (state_q == S_WAIT) && (inflight_q == '0) && !in_req_q.en;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= S_IDLE;
      param_req_q <= '0;
      wgt_req_q   <= '0;
      in_req_q    <= '0;
      out_req_q   <= '0;
      param_vld_q <= 1'b0;
      wgt_vld_q   <= 1'b0;
      rd_vld_q    <= 1'b0;
      finish_q    <= 1'b0;
      inflight_q  <= '0;
    end else begin
      param_req_q.en <= 1'b0;
      out_req_q.en   <= 1'b0;
      out_req_q.we   <= 1'b0;
      finish_q       <= 1'b0;
      param_vld_q    <= param_req_q.en;
      wgt_vld_q      <= wgt_req_q.en;
      wgt_idx_q      <= wgt_req_q.addr[3:0];
      rd_vld_q       <= in_req_q.en;
      rd_k_q         <= req_k_q;
      inflight_q     <= inflight_q + 4'(in_req_q.en) - 4'(rd_vld_q);
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            param_req_q.en <= 1'b1;
            wgt_req_q.en   <= 1'b1;
            wgt_req_q.addr <= '0;
            kr_q           <= '0;
            kc_q           <= '0;
            orow_q         <= '0;
            ocol_q         <= '0;
            wr_addr_q      <= '0;
            state_q        <= S_LOAD;
          end
        end
        S_LOAD: begin
          if (wgt_req_q.en) begin
            if (wgt_req_q.addr == 16'd8) begin
              wgt_req_q.en <= 1'b0;
            end else begin
              wgt_req_q.addr <= wgt_req_q.addr + 16'd1;
            end
          end
          if (load_done) begin
            state_q <= S_ISSUE;
          end
        end
        S_ISSUE: begin
          in_req_q.en   <= 1'b1;
          in_req_q.addr <= rd_addr;
          req_k_q       <= 4'(kr_q * 3 + kc_q);
          if (kc_q == 2'd2) begin
            kc_q <= '0;
            if (kr_q == 2'd2) begin
              kr_q    <= '0;
              state_q <= S_WAIT;
            end else begin
              kr_q <= kr_q + 2'd1;
            end
          end else begin
            kc_q <= kc_q + 2'd1;
          end
        end
        S_WAIT: begin
          in_req_q.en <= 1'b0;
          if (win_done) begin
            out_req_q.en    <= 1'b1;
            out_req_q.we    <= 1'b1;
            out_req_q.addr  <= wr_addr_q;
            out_req_q.wdata <= 32'(conv_post(acc_q, prm_q.conv));
            wr_addr_q       <= wr_addr_q + 16'd1;
            state_q         <= S_ISSUE;
            if (ocol_q == 16'(OUT_W - 1)) begin
              ocol_q <= '0;
              if (orow_q == 16'(OUT_H - 1)) begin
                state_q <= S_LAST;
              end else begin
                orow_q <= orow_q + 16'd1;
              end
            end else begin
              ocol_q <= ocol_q + 16'd1;
            end
          end
        end
        S_LAST: begin
          // Last write is on the bus now
          finish_q <= 1'b1;
          state_q  <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (param_vld_q) begin
      prm_q <= param_rdata_i;
    end
    if (wgt_vld_q) begin
      wgt_q[wgt_idx_q] <= pixel_t'(wgt_rdata_i[7:0]);
    end
    if (load_done || win_done) begin
      acc_q <= 32'(prm_q.conv.bias);
    end else if (rd_vld_q) begin
      acc_q <= acc_q + pixel_t'(in_rdata_i[7:0]) * wgt_q[rd_k_q];
    end
  end

  assign param_req_o = param_req_q;
  assign wgt_req_o   = wgt_req_q;
  assign in_req_o    = in_req_q;
  assign out_req_o   = out_req_q;
  assign finish_o    = finish_q;

endmodule

// ==== verilog/conv_acc.sv ====
module conv_acc #(
  parameter int FMAP_W = 8,
  parameter int FMAP_H = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   start_i,
  input  acc_cfg_pkg::acc_mode_t mode_i,
  output logic                   finish_o,
  output acc_mem_pkg::mem_req_t  param_req_o,
  output acc_mem_pkg::mem_req_t  wgt_req_o,
  output acc_mem_pkg::mem_req_t  in_req_o,
  output acc_mem_pkg::mem_req_t  out_req_o,
  input  acc_mem_pkg::mem_word_t param_rdata_i,
  input  acc_mem_pkg::mem_word_t wgt_rdata_i,
  input  acc_mem_pkg::mem_word_t in_rdata_i
);
  import acc_mem_pkg::*;

  // 1x1 convolution
  logic     c1_start;
  logic     c1_finish;
  mem_req_t c1_param_req;
  mem_req_t c1_wgt_req;
  mem_req_t c1_in_req;
  mem_req_t c1_out_req;

  // 3x3 convolution
  logic     c3_start;
  logic     c3_finish;
  mem_req_t c3_param_req;
  mem_req_t c3_wgt_req;
  mem_req_t c3_in_req;
  mem_req_t c3_out_req;

  // Max pool
  logic     mp_start;
  logic     mp_finish;
  mem_req_t mp_param_req;
  mem_req_t mp_in_req;
  mem_req_t mp_out_req;

  bus_switcher i_bus_switcher (
    .mode_i         (mode_i),
    .start_i        (start_i),
    .finish_o       (finish_o),
    .param_req_o    (param_req_o),
    .wgt_req_o      (wgt_req_o),
    .in_req_o       (in_req_o),
    .out_req_o      (out_req_o),
    .c1_start_o     (c1_start),
    .c1_finish_i    (c1_finish),
    .c1_param_req_i (c1_param_req),
    .c1_wgt_req_i   (c1_wgt_req),
    .c1_in_req_i    (c1_in_req),
    .c1_out_req_i   (c1_out_req),
    .c3_start_o     (c3_start),
    .c3_finish_i    (c3_finish),
    .c3_param_req_i (c3_param_req),
    .c3_wgt_req_i   (c3_wgt_req),
    .c3_in_req_i    (c3_in_req),
    .c3_out_req_i   (c3_out_req),
    .mp_start_o     (mp_start),
    .mp_finish_i    (mp_finish),
    .mp_param_req_i (mp_param_req),
    .mp_in_req_i    (mp_in_req),
    .mp_out_req_i   (mp_out_req)
  );

  // Read data goes to every engine
  conv_1x1 #(
    .FMAP_W (FMAP_W),
    .FMAP_H (FMAP_H)
  ) i_conv_1x1 (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .start_i       (c1_start),
    .finish_o      (c1_finish),
    .param_req_o   (c1_param_req),
    .wgt_req_o     (c1_wgt_req),
    .in_req_o      (c1_in_req),
    .out_req_o     (c1_out_req),
    .param_rdata_i (param_rdata_i),
    .wgt_rdata_i   (wgt_rdata_i),
    .in_rdata_i    (in_rdata_i)
  );

  conv_3x3 #(
    .FMAP_W (FMAP_W),
    .FMAP_H (FMAP_H)
  ) i_conv_3x3 (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .start_i       (c3_start),
    .finish_o      (c3_finish),
    .param_req_o   (c3_param_req),
    .wgt_req_o     (c3_wgt_req),
    .in_req_o      (c3_in_req),
    .out_req_o     (c3_out_req),
    .param_rdata_i (param_rdata_i),
    .wgt_rdata_i   (wgt_rdata_i),
    .in_rdata_i    (in_rdata_i)
  );

  max_pool #(
    .FMAP_W (FMAP_W),
    .FMAP_H (FMAP_H)
  ) i_max_pool (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .start_i       (mp_start),
    .finish_o      (mp_finish),
    .param_req_o   (mp_param_req),
    .in_req_o      (mp_in_req),
    .out_req_o     (mp_out_req),
    .param_rdata_i (param_rdata_i),
    .in_rdata_i    (in_rdata_i)
  );

endmodule

// ==== verilog/max_pool.sv ====
module max_pool #(
  parameter int FMAP_W = 8,
  parameter int FMAP_H = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   start_i,
  output logic                   finish_o,
  output acc_mem_pkg::mem_req_t  param_req_o,
  output acc_mem_pkg::mem_req_t  in_req_o,
  output acc_mem_pkg::mem_req_t  out_req_o,
  input  acc_mem_pkg::mem_word_t param_rdata_i,
  input  acc_mem_pkg::mem_word_t in_rdata_i
);
  import acc_cfg_pkg::*;
  import acc_mem_pkg::*;

  localparam int OUT_W = FMAP_W / 2;
  localparam int OUT_H = FMAP_H / 2;

  typedef enum logic [2:0] {S_IDLE, S_CFG, S_ISSUE, S_WAIT, S_LAST} state_t;

  state_t       state_q;
  mem_req_t     param_req_q;
  mem_req_t     in_req_q;
  mem_req_t     out_req_q;
  logic         cfg_vld_q;
  logic         rd_vld_q;
  logic         finish_q;
  logic         dr_q;
  logic         dc_q;
  logic [15:0]  prow_q;
  logic [15:0]  pcol_q;
  logic [15:0]  wr_addr_q;
  logic [15:0]  rd_addr;
  logic         win_done;
  logic         max_clr;
  layer_param_u prm_q;
  pixel_t       pix;
  pixel_t       max_q;
  pixel_t       pooled;

  assign rd_addr  = 16'((2 * prow_q + 16'(dr_q)) * FMAP_W + 2 * pcol_q + 16'(dc_q));
  assign win_done = (state_q == S_WAIT) && !in_req_q.en && !rd_vld_q;
  assign max_clr  = ((state_q == S_CFG) && cfg_vld_q) || win_done;
  assign pix      = pixel_t'(in_rdata_i[7:0]);
  // Lower clamp
  assign pooled   = (max_q < prm_q.pool.floor) ? prm_q.pool.floor : max_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= S_IDLE;
      param_req_q <= '0;
      in_req_q    <= '0;
      out_req_q   <= '0;
      cfg_vld_q   <= 1'b0;
      rd_vld_q    <= 1'b0;
      finish_q    <= 1'b0;
    end else begin
      param_req_q.en <= 1'b0;
      out_req_q.en   <= 1'b0;
      out_req_q.we   <= 1'b0;
      finish_q       <= 1'b0;
      cfg_vld_q      <= param_req_q.en;
      rd_vld_q       <= in_req_q.en;
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            param_req_q.en <= 1'b1;
            dr_q           <= 1'b0;
            dc_q           <= 1'b0;
            prow_q         <= '0;
            pcol_q         <= '0;
            wr_addr_q      <= '0;
            state_q        <= S_CFG;
          end
        end
        S_CFG: begin
          if (cfg_vld_q) begin
            state_q <= S_ISSUE;
          end
        end
        S_ISSUE: begin
          // Walk the 2x2 block row by row
          in_req_q.en   <= 1'b1;
          in_req_q.addr <= rd_addr;
          dc_q          <= !dc_q;
          if (dc_q) begin
            dr_q <= !dr_q;
            if (dr_q) begin
              state_q <= S_WAIT;
            end
          end
        end
        S_WAIT: begin
          in_req_q.en <= 1'b0;
          if (win_done) begin
            out_req_q.en    <= 1'b1;
            out_req_q.we    <= 1'b1;
            out_req_q.addr  <= wr_addr_q;
            out_req_q.wdata <= 32'(pooled);
            wr_addr_q       <= wr_addr_q + 16'd1;
            state_q         <= S_ISSUE;
            if (pcol_q == 16'(OUT_W - 1)) begin
              pcol_q <= '0;
              if (prow_q == 16'(OUT_H - 1)) begin
                state_q <= S_LAST;
              end else begin
                prow_q <= prow_q + 16'd1;
              end
            end else begin
              pcol_q <= pcol_q + 16'd1;
            end
          end
        end
        S_LAST: begin
          finish_q <= 1'b1;
          state_q  <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg_vld_q) begin
      prm_q <= param_rdata_i;
    end
    if (max_clr) begin
      max_q <= -8'sd128;
    end else if (rd_vld_q && (pix > max_q)) begin
      max_q <= pix;
    end
  end

  assign param_req_o = param_req_q;
  assign in_req_o    = in_req_q;
  assign out_req_o   = out_req_q;
  assign finish_o    = finish_q;

endmodule
